/* source/cpu_pkg.sv */
// constants for the reduced core and only the kept MIPS32 opcodes and funct codes are listed
package cpu_pkg;

    localparam int REG_W      = 32;
    localparam int REG_ADDR_W = 5;
    localparam int DIV_STEPS  = 32;

    localparam logic [REG_W-1:0] RESET_PC = '0;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_LUI     = 6'b001111;

    // funct field of OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'b000000;
    localparam logic [5:0] FN_MFHI = 6'b010000;
    localparam logic [5:0] FN_MFLO = 6'b010010;
    localparam logic [5:0] FN_MULT = 6'b011000;
    localparam logic [5:0] FN_DIV  = 6'b011010;
    localparam logic [5:0] FN_DIVU = 6'b011011;
    localparam logic [5:0] FN_ADDU = 6'b100001;
    localparam logic [5:0] FN_SUBU = 6'b100011;
    localparam logic [5:0] FN_AND  = 6'b100100;
    localparam logic [5:0] FN_OR   = 6'b100101;
    localparam logic [5:0] FN_XOR  = 6'b100110;
    localparam logic [5:0] FN_SLT  = 6'b101010;

    // operation carried from decode to execute
    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT,
        ALU_SLL, ALU_LUI, ALU_MULT, ALU_DIV, ALU_DIVU, ALU_MFHI, ALU_MFLO
    } alu_op_e;

endpackage

/* source/fetch.sv */
// needs a combinational rom and keeps the pc at RESET_PC until rom_ce_o has risen
`timescale 1ns/1ps
module fetch (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      stall_i,
    input  logic                      branch_i,
    input  logic [cpu_pkg::REG_W-1:0] branch_target_i,
    input  logic [cpu_pkg::REG_W-1:0] rom_data_i,
    output logic [cpu_pkg::REG_W-1:0] rom_addr_o,
    output logic                      rom_ce_o,
    output logic [cpu_pkg::REG_W-1:0] id_pc_o,
    output logic [cpu_pkg::REG_W-1:0] id_inst_o
);
    import cpu_pkg::*;

    logic [REG_W-1:0] pc_q;

    // rom enable rises one cycle after reset and the pc starts moving after that
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            rom_ce_o <= 1'b0;
            pc_q     <= RESET_PC;
        end else begin
            rom_ce_o <= 1'b1;
            if (rom_ce_o && !stall_i) begin
                pc_q <= branch_i ? branch_target_i : pc_q + REG_W'(4);
            end
        end
    end

    assign rom_addr_o = pc_q;

    // if/id register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_pc_o   <= RESET_PC;
            id_inst_o <= '0;
        end else if (!stall_i) begin
            id_pc_o   <= pc_q;
            // disabled rom feeds a nop
            id_inst_o <= rom_ce_o ? rom_data_i : '0;
        end
    end

endmodule

/* source/id.sv */
// combinational decode where branches resolve with one delay slot and no likely forms exist
`timescale 1ns/1ps
module id (
    input  logic [cpu_pkg::REG_W-1:0]      pc_i,
    input  logic [cpu_pkg::REG_W-1:0]      inst_i,
    input  logic [cpu_pkg::REG_W-1:0]      reg1_data_i,
    input  logic [cpu_pkg::REG_W-1:0]      reg2_data_i,
    input  logic                           ex_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] ex_addr_i,
    input  logic [cpu_pkg::REG_W-1:0]      ex_data_i,
    input  logic                           wb_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input  logic [cpu_pkg::REG_W-1:0]      wb_data_i,
    output logic [cpu_pkg::REG_ADDR_W-1:0] reg1_addr_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] reg2_addr_o,
    output cpu_pkg::alu_op_e               alu_op_o,
    output logic [cpu_pkg::REG_W-1:0]      opa_o,
    output logic [cpu_pkg::REG_W-1:0]      opb_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] shamt_o,
    output logic                           dest_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] dest_addr_o,
    output logic                           branch_o,
    output logic [cpu_pkg::REG_W-1:0]      branch_target_o
);
    import cpu_pkg::*;

    logic [5:0]       opcode;
    logic [5:0]       funct;
    logic [15:0]      imm;
    logic [REG_W-1:0] pc_plus4;
    logic [REG_W-1:0] rs_val;
    logic [REG_W-1:0] rt_val;

    // the instruction in ex is younger than the one in writeback so it wins
    function automatic logic [REG_W-1:0] fwd(input logic [REG_ADDR_W-1:0] addr,
                                             input logic [REG_W-1:0]      rdata);
        if (addr != '0 && ex_we_i && ex_addr_i == addr) begin
            return ex_data_i;
        end else if (addr != '0 && wb_we_i && wb_addr_i == addr) begin
            return wb_data_i;
        end
        return rdata;
    endfunction

    assign opcode      = inst_i[31:26];
    assign funct       = inst_i[5:0];
    assign imm         = inst_i[15:0];
    assign reg1_addr_o = inst_i[25:21];
    assign reg2_addr_o = inst_i[20:16];
    assign shamt_o     = inst_i[10:6];
    assign pc_plus4    = pc_i + REG_W'(4);

    always_comb begin
        rs_val = fwd(reg1_addr_o, reg1_data_i);
        rt_val = fwd(reg2_addr_o, reg2_data_i);
    end

    always_comb begin
        alu_op_o        = ALU_NOP;
        opa_o           = rs_val;
        opb_o           = rt_val;
        dest_we_o       = 1'b0;
        dest_addr_o     = inst_i[15:11];
        branch_o        = 1'b0;
        branch_target_o = pc_plus4 + {{(REG_W-18){imm[15]}}, imm, 2'b00};
        case (opcode)
            OP_SPECIAL: begin
                dest_we_o = 1'b1;
                case (funct)
                    FN_ADDU: alu_op_o = ALU_ADD;
                    FN_SUBU: alu_op_o = ALU_SUB;
                    FN_AND:  alu_op_o = ALU_AND;
                    FN_OR:   alu_op_o = ALU_OR;
                    FN_XOR:  alu_op_o = ALU_XOR;
                    FN_SLT:  alu_op_o = ALU_SLT;
                    FN_SLL:  alu_op_o = ALU_SLL;
                    FN_MFHI: alu_op_o = ALU_MFHI;
                    FN_MFLO: alu_op_o = ALU_MFLO;
                    // these only write hi and lo
                    FN_MULT, FN_DIV, FN_DIVU: begin
                        dest_we_o = 1'b0;
                        alu_op_o  = (funct == FN_MULT) ? ALU_MULT :
                                    (funct == FN_DIV) ? ALU_DIV : ALU_DIVU;
                    end
                    default: dest_we_o = 1'b0;
                endcase
            end
            OP_ORI, OP_LUI: begin
                alu_op_o    = (opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                opb_o       = {{(REG_W-16){1'b0}}, imm};
                dest_we_o   = 1'b1;
                dest_addr_o = inst_i[20:16];
            end
            OP_BEQ: branch_o = (rs_val == rt_val);
            OP_BNE: branch_o = (rs_val != rt_val);
            OP_J: begin
                branch_o        = 1'b1;
                branch_target_o = {pc_plus4[REG_W-1:28], inst_i[25:0], 2'b00};
            end
            default: ;
        endcase
        // writes to r0 die here so no later stage sees them
        if (dest_addr_o == '0) begin
            dest_we_o = 1'b0;
        end
    end

endmodule

/* source/regfile.sv */
// combinational reads with no write bypass since decode forwards from writeback itself
`timescale 1ns/1ps
module regfile (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] waddr_i,
    input  logic [cpu_pkg::REG_W-1:0]      wdata_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr1_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] raddr2_i,
    output logic [cpu_pkg::REG_W-1:0]      rdata1_o,
    output logic [cpu_pkg::REG_W-1:0]      rdata2_o,
    input  logic                           hilo_we_i,
    input  logic [cpu_pkg::REG_W-1:0]      hi_i,
    input  logic [cpu_pkg::REG_W-1:0]      lo_i,
    output logic [cpu_pkg::REG_W-1:0]      hi_o,
    output logic [cpu_pkg::REG_W-1:0]      lo_o
);
    import cpu_pkg::*;

    logic [REG_W-1:0] gpr_q [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                gpr_q[i] <= '0;
            end
            hi_o <= '0;
            lo_o <= '0;
        end else begin
            if (we_i && waddr_i != '0) begin
                gpr_q[waddr_i] <= wdata_i;
            end
            if (hilo_we_i) begin
                hi_o <= hi_i;
                lo_o <= lo_i;
            end
        end
    end

    // r0 always reads zero
    assign rdata1_o = (raddr1_i == '0) ? '0 : gpr_q[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : gpr_q[raddr2_i];

endmodule

/* source/id_ex.sv */
// holds its contents under stall and never makes a bubble of its own
`timescale 1ns/1ps
module id_ex (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  cpu_pkg::alu_op_e               alu_op_i,
    input  logic [cpu_pkg::REG_W-1:0]      opa_i,
    input  logic [cpu_pkg::REG_W-1:0]      opb_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] shamt_i,
    input  logic                           dest_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] dest_addr_i,
    output cpu_pkg::alu_op_e               ex_alu_op_o,
    output logic [cpu_pkg::REG_W-1:0]      ex_opa_o,
    output logic [cpu_pkg::REG_W-1:0]      ex_opb_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_shamt_o,
    output logic                           ex_dest_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] ex_dest_addr_o
);
    import cpu_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ex_alu_op_o  <= ALU_NOP;
            ex_dest_we_o <= 1'b0;
        end else if (!stall_i) begin
            ex_alu_op_o    <= alu_op_i;
            ex_dest_we_o   <= dest_we_i;
            ex_opa_o       <= opa_i;
            ex_opb_o       <= opb_i;
            ex_shamt_o     <= shamt_i;
            ex_dest_addr_o <= dest_addr_i;
        end
    end

endmodule

/* source/ex.sv */
// single-cycle alu and signed multiply while a divide keeps the front stalled until ready
`timescale 1ns/1ps
module ex (
    input  cpu_pkg::alu_op_e               alu_op_i,
    input  logic [cpu_pkg::REG_W-1:0]      opa_i,
    input  logic [cpu_pkg::REG_W-1:0]      opb_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] shamt_i,
    input  logic                           dest_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] dest_addr_i,
    input  logic [cpu_pkg::REG_W-1:0]      hi_i,
    input  logic [cpu_pkg::REG_W-1:0]      lo_i,
    input  logic                           wb_hilo_we_i,
    input  logic [cpu_pkg::REG_W-1:0]      wb_hi_i,
    input  logic [cpu_pkg::REG_W-1:0]      wb_lo_i,
    input  logic                           div_ready_i,
    input  logic [cpu_pkg::REG_W-1:0]      div_quot_i,
    input  logic [cpu_pkg::REG_W-1:0]      div_rem_i,
    output logic                           res_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] res_addr_o,
    output logic [cpu_pkg::REG_W-1:0]      res_data_o,
    output logic                           hilo_we_o,
    output logic [cpu_pkg::REG_W-1:0]      hi_o,
    output logic [cpu_pkg::REG_W-1:0]      lo_o,
    output logic                           stall_o,
    output logic                           div_start_o,
    output logic                           div_signed_o,
    output logic [cpu_pkg::REG_W-1:0]      div_opa_o,
    output logic [cpu_pkg::REG_W-1:0]      div_opb_o
);
    import cpu_pkg::*;

    logic signed [2*REG_W-1:0] prod;
    logic [REG_W-1:0]          hi_fwd;
    logic [REG_W-1:0]          lo_fwd;

    assign prod = $signed(opa_i) * $signed(opb_i);

    // hi/lo from the instruction in writeback are not in the register yet
    assign hi_fwd = wb_hilo_we_i ? wb_hi_i : hi_i;
    assign lo_fwd = wb_hilo_we_i ? wb_lo_i : lo_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  res_data_o = opa_i + opb_i;
            ALU_SUB:  res_data_o = opa_i - opb_i;
            ALU_AND:  res_data_o = opa_i & opb_i;
            ALU_OR:   res_data_o = opa_i | opb_i;
            ALU_XOR:  res_data_o = opa_i ^ opb_i;
            ALU_SLT:  res_data_o = {{(REG_W-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
            ALU_SLL:  res_data_o = opb_i << shamt_i;
            ALU_LUI:  res_data_o = {opb_i[REG_W/2-1:0], {(REG_W/2){1'b0}}};
            ALU_MFHI: res_data_o = hi_fwd;
            ALU_MFLO: res_data_o = lo_fwd;
            default:  res_data_o = '0;
        endcase
    end

    assign res_we_o   = dest_we_i;
    assign res_addr_o = dest_addr_i;

    // start stays up through the ready cycle and falls once the divide moves on
    assign div_start_o  = (alu_op_i == ALU_DIV) || (alu_op_i == ALU_DIVU);
    assign div_signed_o = (alu_op_i == ALU_DIV);
    assign div_opa_o    = opa_i;
    assign div_opb_o    = opb_i;
    assign stall_o      = div_start_o && !div_ready_i;

    // hi gets the remainder and lo the quotient
    assign hilo_we_o = (alu_op_i == ALU_MULT) || (div_start_o && div_ready_i);
    assign hi_o      = div_start_o ? div_rem_i : prod[2*REG_W-1:REG_W];
    assign lo_o      = div_start_o ? div_quot_i : prod[REG_W-1:0];

endmodule

/* source/div.sv */
// restoring divider taking DIV_STEPS+2 cycles to ready and one cycle for a zero divisor, no annul
`timescale 1ns/1ps
module div (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      start_i,
    input  logic                      signed_i,
    input  logic [cpu_pkg::REG_W-1:0] opa_i,
    input  logic [cpu_pkg::REG_W-1:0] opb_i,
    output logic                      ready_o,
    output logic [cpu_pkg::REG_W-1:0] quot_o,
    output logic [cpu_pkg::REG_W-1:0] rem_o
);
    import cpu_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_e;

    state_e                         state_q;
    logic [$clog2(DIV_STEPS+1)-1:0] cnt_q;
    logic [REG_W-1:0]               quo_q;
    logic [REG_W-1:0]               rem_q;
    logic [REG_W-1:0]               dvs_q;
    logic                           neg_quo_q;
    logic                           neg_rem_q;
    logic [REG_W-1:0]               abs_a;
    logic [REG_W-1:0]               abs_b;
    logic [REG_W:0]                 shifted;
    logic [REG_W+1:0]               trial;

    assign abs_a   = (signed_i && opa_i[REG_W-1]) ? -opa_i : opa_i;
    assign abs_b   = (signed_i && opb_i[REG_W-1]) ? -opb_i : opb_i;
    assign shifted = {rem_q, quo_q[REG_W-1]};
    assign trial   = {1'b0, shifted} - {2'b00, dvs_q};

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= S_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                S_IDLE: if (start_i) begin
                    cnt_q   <= '0;
                    state_q <= (opb_i == '0) ? S_DONE : S_RUN;
                end
                // last run cycle fixes the signs
                S_RUN: begin
                    cnt_q <= cnt_q + 1'b1;
                    if (int'(cnt_q) == DIV_STEPS) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && start_i) begin
            neg_quo_q <= signed_i && (opa_i[REG_W-1] ^ opb_i[REG_W-1]);
            neg_rem_q <= signed_i && opa_i[REG_W-1];
            dvs_q     <= abs_b;
            // zero divisor loads the final result straight away
            quo_q     <= (opb_i == '0) ? '1 : abs_a;
            rem_q     <= (opb_i == '0) ? opa_i : '0;
        end else if (state_q == S_RUN) begin
            if (int'(cnt_q) < DIV_STEPS) begin
                quo_q <= {quo_q[REG_W-2:0], !trial[REG_W+1]};
                rem_q <= trial[REG_W+1] ? shifted[REG_W-1:0] : trial[REG_W-1:0];
            end else begin
                quo_q <= neg_quo_q ? -quo_q : quo_q;
                rem_q <= neg_rem_q ? -rem_q : rem_q;
            end
        end
    end

    assign ready_o = (state_q == S_DONE);
    assign quot_o  = quo_q;
    assign rem_o   = rem_q;

endmodule

/* source/ex_wb.sv */
// a stalled execute sends a bubble so a long divide reaches writeback only once
`timescale 1ns/1ps
module ex_wb (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           stall_i,
    input  logic                           res_we_i,
    input  logic [cpu_pkg::REG_ADDR_W-1:0] res_addr_i,
    input  logic [cpu_pkg::REG_W-1:0]      res_data_i,
    input  logic                           hilo_we_i,
    input  logic [cpu_pkg::REG_W-1:0]      hi_i,
    input  logic [cpu_pkg::REG_W-1:0]      lo_i,
    output logic                           wb_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [cpu_pkg::REG_W-1:0]      wb_data_o,
    output logic                           hilo_we_o,
    output logic [cpu_pkg::REG_W-1:0]      hi_o,
    output logic [cpu_pkg::REG_W-1:0]      lo_o
);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_o   <= 1'b0;
            hilo_we_o <= 1'b0;
        end else begin
            wb_we_o   <= res_we_i && !stall_i;
            hilo_we_o <= hilo_we_i && !stall_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_addr_o <= res_addr_i;
        wb_data_o <= res_data_i;
        hi_o      <= hi_i;
        lo_o      <= lo_i;
    end

endmodule

/* source/mips_core.sv */
// four-stage core with no loads, stores or exceptions and the rom outside must answer in the cycle
`timescale 1ns/1ps
module mips_core (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic [cpu_pkg::REG_W-1:0]      rom_data_i,
    output logic [cpu_pkg::REG_W-1:0]      rom_addr_o,
    output logic                           rom_ce_o,
    output logic                           wb_we_o,
    output logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_o,
    output logic [cpu_pkg::REG_W-1:0]      wb_data_o
);
    import cpu_pkg::*;

    // fetch to decode and register reads
    logic                  stall, branch;
    logic [REG_W-1:0]      branch_target, id_pc, id_inst;
    logic [REG_ADDR_W-1:0] reg1_addr, reg2_addr;
    logic [REG_W-1:0]      reg1_data, reg2_data;

    // decode to execute
    alu_op_e               id_alu_op, ex_alu_op;
    logic [REG_W-1:0]      id_opa, id_opb, ex_opa, ex_opb;
    logic [REG_ADDR_W-1:0] id_shamt, id_dest_addr, ex_shamt, ex_dest_addr;
    logic                  id_dest_we, ex_dest_we;

    // execute results and hi/lo
    logic                  res_we, ex_hilo_we, wb_hilo_we;
    logic [REG_ADDR_W-1:0] res_addr;
    logic [REG_W-1:0]      res_data, ex_hi, ex_lo, wb_hi, wb_lo, hi, lo;

    // divider side unit
    logic                  div_start, div_signed, div_ready;
    logic [REG_W-1:0]      div_opa, div_opb, div_quot, div_rem;

    fetch fetch0 (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall),
        .branch_i(branch), .branch_target_i(branch_target),
        .rom_data_i(rom_data_i), .rom_addr_o(rom_addr_o), .rom_ce_o(rom_ce_o),
        .id_pc_o(id_pc), .id_inst_o(id_inst)
    );

    id id0 (
        .pc_i(id_pc), .inst_i(id_inst),
        .reg1_data_i(reg1_data), .reg2_data_i(reg2_data),
        .ex_we_i(res_we), .ex_addr_i(res_addr), .ex_data_i(res_data),
        .wb_we_i(wb_we_o), .wb_addr_i(wb_addr_o), .wb_data_i(wb_data_o),
        .reg1_addr_o(reg1_addr), .reg2_addr_o(reg2_addr),
        .alu_op_o(id_alu_op), .opa_o(id_opa), .opb_o(id_opb), .shamt_o(id_shamt),
        .dest_we_o(id_dest_we), .dest_addr_o(id_dest_addr),
        .branch_o(branch), .branch_target_o(branch_target)
    );

    regfile regfile0 (
        .clk(clk), .rst_n_i(rst_n_i),
        .we_i(wb_we_o), .waddr_i(wb_addr_o), .wdata_i(wb_data_o),
        .raddr1_i(reg1_addr), .raddr2_i(reg2_addr),
        .rdata1_o(reg1_data), .rdata2_o(reg2_data),
        .hilo_we_i(wb_hilo_we), .hi_i(wb_hi), .lo_i(wb_lo),
        .hi_o(hi), .lo_o(lo)
    );

    id_ex id_ex0 (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall),
        .alu_op_i(id_alu_op), .opa_i(id_opa), .opb_i(id_opb), .shamt_i(id_shamt),
        .dest_we_i(id_dest_we), .dest_addr_i(id_dest_addr),
        .ex_alu_op_o(ex_alu_op), .ex_opa_o(ex_opa), .ex_opb_o(ex_opb),
        .ex_shamt_o(ex_shamt), .ex_dest_we_o(ex_dest_we), .ex_dest_addr_o(ex_dest_addr)
    );

    ex ex0 (
        .alu_op_i(ex_alu_op), .opa_i(ex_opa), .opb_i(ex_opb), .shamt_i(ex_shamt),
        .dest_we_i(ex_dest_we), .dest_addr_i(ex_dest_addr),
        .hi_i(hi), .lo_i(lo),
        .wb_hilo_we_i(wb_hilo_we), .wb_hi_i(wb_hi), .wb_lo_i(wb_lo),
        .div_ready_i(div_ready), .div_quot_i(div_quot), .div_rem_i(div_rem),
        .res_we_o(res_we), .res_addr_o(res_addr), .res_data_o(res_data),
        .hilo_we_o(ex_hilo_we), .hi_o(ex_hi), .lo_o(ex_lo),
        .stall_o(stall), .div_start_o(div_start), .div_signed_o(div_signed),
        .div_opa_o(div_opa), .div_opb_o(div_opb)
    );

    div div0 (
        .clk(clk), .rst_n_i(rst_n_i),
        .start_i(div_start), .signed_i(div_signed), .opa_i(div_opa), .opb_i(div_opb),
        .ready_o(div_ready), .quot_o(div_quot), .rem_o(div_rem)
    );

    ex_wb ex_wb0 (
        .clk(clk), .rst_n_i(rst_n_i), .stall_i(stall),
        .res_we_i(res_we), .res_addr_i(res_addr), .res_data_i(res_data),
        .hilo_we_i(ex_hilo_we), .hi_i(ex_hi), .lo_i(ex_lo),
        .wb_we_o(wb_we_o), .wb_addr_o(wb_addr_o), .wb_data_o(wb_data_o),
        .hilo_we_o(wb_hilo_we), .hi_o(wb_hi), .lo_o(wb_lo)
    );

endmodule

/* bench/tb_clock.sv */
// free-running clock with a 4 ns period that starts low and never stops
`timescale 1ns/1ps
module tb_clock (
    output logic clk_o
);

    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o;
        end
    end

endmodule

/* bench/mips_core_props.sv */
// sampled on the rising edge and expects the synchronous reset to be applied for at least one cycle
`timescale 1ns/1ps
module mips_core_props (
    input logic                           clk,
    input logic                           rst_n_i,
    input logic                           rom_ce_i,
    input logic [cpu_pkg::REG_W-1:0]      rom_addr_i,
    input logic                           wb_we_i,
    input logic [cpu_pkg::REG_ADDR_W-1:0] wb_addr_i,
    input logic                           stall_i,
    input logic                           div_start_i,
    input logic                           div_ready_i
);

    // the enable register clears on every reset edge
    rom_ce_low_in_reset: assert property (@(posedge clk) !rst_n_i |=> !rom_ce_i)
        else $error("rom enable is high after a reset cycle");

    no_write_to_r0: assert property (@(posedge clk) disable iff (!rst_n_i)
        wb_we_i |-> wb_addr_i != '0)
        else $error("writeback targets register zero");

    // fetch must not move while the divider holds the front
    fetch_held_in_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i |=> $stable(rom_addr_i))
        else $error("fetch address moved during a stall");

    div_start_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        div_start_i && !div_ready_i |=> div_start_i)
        else $error("divider start dropped before ready");

endmodule

bind mips_core mips_core_props props_i (
    .clk(clk),
    .rst_n_i(rst_n_i),
    .rom_ce_i(rom_ce_o),
    .rom_addr_i(rom_addr_o),
    .wb_we_i(wb_we_o),
    .wb_addr_i(wb_addr_o),
    .stall_i(stall),
    .div_start_i(div_start),
    .div_ready_i(div_ready)
);

/* bench/tb_mips_core.sv */
// runs one fixed program from a combinational rom model and expects every writeback in program order
`timescale 1ns/1ps
module tb_mips_core;
    import cpu_pkg::*;

    localparam int RESET_CYCLES    = 8;
    localparam int PROG_LEN        = 39;
    localparam int EXP_LEN         = 28;
    localparam int ROM_WORDS       = 64;
    localparam int WATCHDOG_CYCLES = PROG_LEN * (DIV_STEPS + 8);
    // a few fetches past the end so the last instruction has left the pipeline
    localparam logic [REG_W-1:0] DRAIN_ADDR = (PROG_LEN + 4) * 4;

    logic                  clk;
    logic                  rst_n;
    logic [REG_W-1:0]      rom_data;
    logic [REG_W-1:0]      rom_addr;
    logic                  rom_ce;
    logic                  wb_we;
    logic [REG_ADDR_W-1:0] wb_addr;
    logic [REG_W-1:0]      wb_data;

    logic [REG_W-1:0]      rom [ROM_WORDS];
    logic [REG_W-1:0]      prog_q [$];
    string                 exp_name [$];
    logic [REG_ADDR_W-1:0] exp_reg [$];
    logic [REG_W-1:0]      exp_data [$];
    int                    wb_count = 0;
    int                    value_errors = 0;
    int                    other_errors = 0;

    tb_clock clock_i (.clk_o(clk));

    mips_core dut_i (
        .clk(clk), .rst_n_i(rst_n), .rom_data_i(rom_data),
        .rom_addr_o(rom_addr), .rom_ce_o(rom_ce),
        .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data)
    );

    // addresses past the program read as nop
    assign rom_data = (rom_ce && rom_addr < REG_W'(PROG_LEN * 4)) ? rom[rom_addr[7:2]] : '0;

    function automatic logic [REG_W-1:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                                input logic [4:0] rd, input logic [4:0] shamt,
                                                input logic [5:0] funct);
        return {OP_SPECIAL, rs, rt, rd, shamt, funct};
    endfunction

    function automatic logic [REG_W-1:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [REG_W-1:0] j_word(input logic [25:0] target);
        return {OP_J, target};
    endfunction

    task automatic check_value(input string name, input logic [REG_W-1:0] expected,
                               input logic [REG_W-1:0] actual);
        if (actual !== expected) begin
            value_errors++;
            $display("Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic add_expected(input string name, input logic [REG_ADDR_W-1:0] rd,
                                input logic [REG_W-1:0] value);
        exp_name.push_back(name);
        exp_reg.push_back(rd);
        exp_data.push_back(value);
    endtask

    task automatic build_program();
        // alu chain where each result feeds the next
        prog_q.push_back(i_word(OP_ORI, 0, 1, 16'h1234));
        prog_q.push_back(i_word(OP_LUI, 0, 2, 16'h8765));
        prog_q.push_back(i_word(OP_ORI, 2, 2, 16'h4321));
        prog_q.push_back(r_word(2, 1, 3, 0, FN_ADDU));
        prog_q.push_back(r_word(3, 1, 4, 0, FN_SUBU));
        prog_q.push_back(r_word(4, 3, 5, 0, FN_AND));
        prog_q.push_back(r_word(5, 1, 6, 0, FN_OR));
        prog_q.push_back(r_word(6, 2, 7, 0, FN_XOR));
        prog_q.push_back(r_word(2, 7, 8, 0, FN_SLT));
        prog_q.push_back(r_word(0, 8, 9, 5, FN_SLL));
        prog_q.push_back(r_word(9, 8, 10, 0, FN_SLT));
        // r2 times 32 read back at once
        prog_q.push_back(r_word(2, 9, 0, 0, FN_MULT));
        prog_q.push_back(r_word(0, 0, 11, 0, FN_MFHI));
        prog_q.push_back(r_word(0, 0, 12, 0, FN_MFLO));
        // -23 / 7 signed and unsigned then 0x1234 / -23 and 0x1234 / 0
        prog_q.push_back(i_word(OP_LUI, 0, 14, 16'hffff));
        prog_q.push_back(i_word(OP_ORI, 14, 14, 16'hffe9));
        prog_q.push_back(i_word(OP_ORI, 0, 13, 16'h0007));
        prog_q.push_back(r_word(14, 13, 0, 0, FN_DIV));
        prog_q.push_back(r_word(0, 0, 15, 0, FN_MFLO));
        prog_q.push_back(r_word(0, 0, 16, 0, FN_MFHI));
        prog_q.push_back(r_word(14, 13, 0, 0, FN_DIVU));
        prog_q.push_back(r_word(0, 0, 17, 0, FN_MFLO));
        prog_q.push_back(r_word(0, 0, 18, 0, FN_MFHI));
        prog_q.push_back(r_word(1, 14, 0, 0, FN_DIV));
        prog_q.push_back(r_word(0, 0, 19, 0, FN_MFLO));
        prog_q.push_back(r_word(1, 0, 0, 0, FN_DIVU));
        prog_q.push_back(r_word(0, 0, 20, 0, FN_MFHI));
        prog_q.push_back(r_word(0, 0, 21, 0, FN_MFLO));
        // taken beq runs its slot at word 29 and lands on word 31 past word 30
        prog_q.push_back(i_word(OP_BEQ, 4, 2, 16'd2));
        prog_q.push_back(i_word(OP_ORI, 0, 22, 16'h0022));
        prog_q.push_back(i_word(OP_ORI, 0, 23, 16'h0bad));
        // bne on equal operands falls through
        prog_q.push_back(i_word(OP_BNE, 22, 22, 16'd4));
        prog_q.push_back(i_word(OP_ORI, 0, 24, 16'h0024));
        prog_q.push_back(i_word(OP_ORI, 0, 25, 16'h0025));
        // j to word 37 skips word 36
        prog_q.push_back(j_word(26'd37));
        prog_q.push_back(i_word(OP_ORI, 0, 26, 16'h0026));
        prog_q.push_back(i_word(OP_ORI, 0, 27, 16'h0bad));
        prog_q.push_back(i_word(OP_ORI, 0, 0, 16'hdead));
        prog_q.push_back(r_word(0, 25, 28, 0, FN_ADDU));
    endtask

    task automatic build_expected();
        add_expected("ori_first", 1, 32'h0000_1234);
        add_expected("lui", 2, 32'h8765_0000);
        add_expected("ori_fwd_ex", 2, 32'h8765_4321);
        add_expected("addu", 3, 32'h8765_5555);
        add_expected("subu", 4, 32'h8765_4321);
        add_expected("and", 5, 32'h8765_4101);
        add_expected("or", 6, 32'h8765_5335);
        add_expected("xor", 7, 32'h0000_1014);
        add_expected("slt_neg_pos", 8, 32'h0000_0001);
        add_expected("sll", 9, 32'h0000_0020);
        add_expected("slt_not_less", 10, 32'h0000_0000);
        // -0x789abcdf * 32
        add_expected("mult_hi", 11, 32'hffff_fff0);
        add_expected("mult_lo", 12, 32'heca8_6420);
        add_expected("lui_upper_ones", 14, 32'hffff_0000);
        add_expected("ori_minus_23", 14, 32'hffff_ffe9);
        add_expected("ori_seven", 13, 32'h0000_0007);
        add_expected("div_quot", 15, 32'hffff_fffd);
        add_expected("div_rem", 16, 32'hffff_fffe);
        add_expected("divu_quot", 17, 32'h2492_4921);
        add_expected("divu_rem", 18, 32'h0000_0002);
        add_expected("div_neg_divisor_quot", 19, 32'hffff_ff36);
        add_expected("div_by_zero_rem", 20, 32'h0000_1234);
        add_expected("div_by_zero_quot", 21, 32'hffff_ffff);
        add_expected("beq_delay_slot", 22, 32'h0000_0022);
        add_expected("bne_delay_slot", 24, 32'h0000_0024);
        add_expected("bne_fall_through", 25, 32'h0000_0025);
        add_expected("j_delay_slot", 26, 32'h0000_0026);
        add_expected("r0_reads_zero", 28, 32'h0000_0025);
    endtask

    // each writeback takes the next table entry in program order
    always @(negedge clk) begin
        if (rst_n && wb_we) begin
            if (wb_count < EXP_LEN) begin
                check_value({exp_name[wb_count], "_reg"}, REG_W'(exp_reg[wb_count]),
                            REG_W'(wb_addr));
                check_value(exp_name[wb_count], exp_data[wb_count], wb_data);
            end else begin
                other_errors++;
                $display("unexpected writeback of %h to r%0d after the last expected one",
                         wb_data, wb_addr);
            end
            wb_count++;
        end
    end

    initial begin
        rst_n = 1'b0;
        build_program();
        build_expected();
        check_value("program_length", PROG_LEN, prog_q.size());
        check_value("expected_length", EXP_LEN, exp_name.size());
        for (int i = 0; i < PROG_LEN; i++) begin
            rom[i] = prog_q[i];
        end
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_value("rom_ce_in_reset", '0, REG_W'(rom_ce));
        end
        @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        while (rom_ce !== 1'b1) @(negedge clk);
        check_value("first_fetch_addr", RESET_PC, rom_addr);
        // done once fetch has run past the end of the program
        while (rom_addr < DRAIN_ADDR) @(negedge clk);
        if (wb_count < EXP_LEN) begin
            other_errors++;
            $display("only %0d of %0d expected writebacks arrived", wb_count, EXP_LEN);
        end
        $display("%0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the program did not finish",
                 WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* sim.f */
source/cpu_pkg.sv
source/fetch.sv
source/id.sv
source/regfile.sv
source/id_ex.sv
source/ex.sv
source/div.sv
source/ex_wb.sv
source/mips_core.sv
bench/tb_clock.sv
bench/mips_core_props.sv
bench/tb_mips_core.sv

/* Makefile */
# Verilator flow for the reduced MIPS core testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_core
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all build run clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass message shows up in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
